/* Makefile */
# Verilator build and run of the execute stage testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_ex_stage with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f sources.f --top-module tb_ex_stage -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/ex_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_checker (
	input  logic                      clk,
	input  logic                      reset_i,
	input  logic                      check_i,
	input  logic [`EX_REGADDR_W-1:0]  exp_wd_i,
	input  logic                      exp_wreg_i,
	input  logic [`EX_DATA_W-1:0]     exp_wdata_i,
	input  logic                      exp_ov_i,
	input  logic [`EX_DATA_W-1:0]     exp_hi_i,
	input  logic [`EX_DATA_W-1:0]     exp_lo_i,
	input  logic                      exp_whilo_i,
	input  logic [`EX_REGADDR_W-1:0]  dut_wd_i,
	input  logic                      dut_wreg_i,
	input  logic [`EX_DATA_W-1:0]     dut_wdata_i,
	input  logic                      dut_ov_i,
	input  logic [`EX_DATA_W-1:0]     dut_hi_i,
	input  logic [`EX_DATA_W-1:0]     dut_lo_i,
	input  logic                      dut_whilo_i,
	output int                        error_count_o,
	output int                        check_count_o
);

	int   errors = 0;
	int   checks = 0;
	logic in_reset = 1'b0;

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] time %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	always @(posedge clk) begin
		// outputs now visible were registered under reset at the previous edge,
		// this includes the first cycle after reset_i falls
		if (in_reset) begin
			compare_value("wreg_o", 32'h0, 32'(dut_wreg_i));
			compare_value("whilo_o", 32'h0, 32'(dut_whilo_i));
			compare_value("ov_o", 32'h0, 32'(dut_ov_i));
		end
		in_reset = reset_i;

		if (check_i) begin
			checks++;
			compare_value("wd_o", 32'(exp_wd_i), 32'(dut_wd_i));
			compare_value("wreg_o", 32'(exp_wreg_i), 32'(dut_wreg_i));
			compare_value("ov_o", 32'(exp_ov_i), 32'(dut_ov_i));
			compare_value("whilo_o", 32'(exp_whilo_i), 32'(dut_whilo_i));
			// write data only matters when it is written
			if (exp_wreg_i)
				compare_value("wdata_o", exp_wdata_i, dut_wdata_i);
			if (exp_whilo_i) begin
				compare_value("hi_o", exp_hi_i, dut_hi_i);
				compare_value("lo_o", exp_lo_i, dut_lo_i);
			end
		end
	end

	assign error_count_o = errors;
	assign check_count_o = checks;

endmodule

`default_nettype wire

/* bench/tb_ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module tb_ex_stage;

	// hi/lo sources, one distinct value per stage
	localparam logic [`EX_DATA_W-1:0] RF_HI  = 32'h1000_0001;
	localparam logic [`EX_DATA_W-1:0] RF_LO  = 32'h1000_0002;
	localparam logic [`EX_DATA_W-1:0] WB_HI  = 32'h2000_0001;
	localparam logic [`EX_DATA_W-1:0] WB_LO  = 32'h2000_0002;
	localparam logic [`EX_DATA_W-1:0] MEM_HI = 32'h3000_0001;
	localparam logic [`EX_DATA_W-1:0] MEM_LO = 32'h3000_0002;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = 50;

	typedef struct packed {
		ex_pkg::aluop_e            op;
		ex_pkg::alusel_e           sel;
		logic [`EX_DATA_W-1:0]     reg1;
		logic [`EX_DATA_W-1:0]     reg2;
		logic [`EX_REGADDR_W-1:0]  wd;
		logic                      wreg;
		logic                      mem_whilo;
		logic                      wb_whilo;
		logic                      exp_wreg;
		logic [`EX_DATA_W-1:0]     exp_wdata;
		logic                      exp_ov;
		logic [`EX_DATA_W-1:0]     exp_hi;
		logic [`EX_DATA_W-1:0]     exp_lo;
		logic                      exp_whilo;
	} row_t;

	logic                     clk;
	logic                     reset_i;
	ex_pkg::aluop_e           aluop;
	ex_pkg::alusel_e          alusel;
	logic [`EX_DATA_W-1:0]    reg1;
	logic [`EX_DATA_W-1:0]    reg2;
	logic [`EX_REGADDR_W-1:0] wd;
	logic                     wreg;
	logic [`EX_DATA_W-1:0]    hi;
	logic [`EX_DATA_W-1:0]    lo;
	logic [`EX_DATA_W-1:0]    mem_hi;
	logic [`EX_DATA_W-1:0]    mem_lo;
	logic [`EX_DATA_W-1:0]    wb_hi;
	logic [`EX_DATA_W-1:0]    wb_lo;
	logic                     mem_whilo;
	logic                     wb_whilo;
	logic [`EX_REGADDR_W-1:0] dut_wd;
	logic                     dut_wreg;
	logic [`EX_DATA_W-1:0]    dut_wdata;
	logic                     dut_ov;
	logic [`EX_DATA_W-1:0]    dut_hi;
	logic [`EX_DATA_W-1:0]    dut_lo;
	logic                     dut_whilo;

	logic                     check;
	logic [`EX_REGADDR_W-1:0] exp_wd;
	logic                     exp_wreg;
	logic [`EX_DATA_W-1:0]    exp_wdata;
	logic                     exp_ov;
	logic [`EX_DATA_W-1:0]    exp_hi;
	logic [`EX_DATA_W-1:0]    exp_lo;
	logic                     exp_whilo;
	int                       error_count;
	int                       check_count;

	row_t rows[$];
	row_t idle_row;
	int   seed;
	logic run_ok;

	ex_stage UUT (
		.clk(clk), .reset_i(reset_i), .aluop_i(aluop), .alusel_i(alusel),
		.reg1_i(reg1), .reg2_i(reg2), .wd_i(wd), .wreg_i(wreg),
		.hi_i(hi), .lo_i(lo), .mem_hi_i(mem_hi), .mem_lo_i(mem_lo),
		.wb_hi_i(wb_hi), .wb_lo_i(wb_lo), .mem_whilo_i(mem_whilo), .wb_whilo_i(wb_whilo),
		.wd_o(dut_wd), .wreg_o(dut_wreg), .wdata_o(dut_wdata), .ov_o(dut_ov),
		.hi_o(dut_hi), .lo_o(dut_lo), .whilo_o(dut_whilo)
	);

	ex_checker u_checker (
		.clk(clk), .reset_i(reset_i), .check_i(check),
		.exp_wd_i(exp_wd), .exp_wreg_i(exp_wreg), .exp_wdata_i(exp_wdata), .exp_ov_i(exp_ov),
		.exp_hi_i(exp_hi), .exp_lo_i(exp_lo), .exp_whilo_i(exp_whilo),
		.dut_wd_i(dut_wd), .dut_wreg_i(dut_wreg), .dut_wdata_i(dut_wdata), .dut_ov_i(dut_ov),
		.dut_hi_i(dut_hi), .dut_lo_i(dut_lo), .dut_whilo_i(dut_whilo),
		.error_count_o(error_count), .check_count_o(check_count)
	);

	////////////////////////////////////////
	// table rows
	////////////////////////////////////////

	task automatic push_hilo_row(input ex_pkg::aluop_e op, input ex_pkg::alusel_e sel,
		input logic [31:0] a, input logic [31:0] b, input logic mem_w, input logic wb_w,
		input logic wr, input logic [31:0] data, input logic whilo_w,
		input logic [31:0] new_hi, input logic [31:0] new_lo);
		row_t r;
		int   idx;
		idx = rows.size();
		r = '0;
		r.op = op;
		r.sel = sel;
		r.reg1 = a;
		r.reg2 = b;
		r.wd = idx[`EX_REGADDR_W-1:0];
		r.wreg = wr;
		r.mem_whilo = mem_w;
		r.wb_whilo = wb_w;
		r.exp_wreg = wr;
		r.exp_wdata = data;
		r.exp_whilo = whilo_w;
		r.exp_hi = new_hi;
		r.exp_lo = new_lo;
		rows.push_back(r);
	endtask

	task automatic add_alu_row(input ex_pkg::aluop_e op, input ex_pkg::alusel_e sel,
		input logic [31:0] a, input logic [31:0] b, input logic wr,
		input logic [31:0] data, input logic ov);
		push_hilo_row(op, sel, a, b, 1'b0, 1'b0, wr, data, 1'b0, 32'h0, 32'h0);
		// overflow drops the write and raises the flag
		rows[rows.size()-1].exp_wreg = wr & ~ov;
		rows[rows.size()-1].exp_ov = ov;
	endtask

	task automatic build_table();
		logic [31:0] a;
		logic [31:0] b;
		add_alu_row(ex_pkg::ALU_NOP, ex_pkg::SEL_NONE, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0);
		add_alu_row(ex_pkg::ALU_AND, ex_pkg::SEL_LOGIC, 32'hF0F0_1234, 32'h0FF0_FFFF, 1'b1,
			32'h00F0_1234, 1'b0);
		add_alu_row(ex_pkg::ALU_OR, ex_pkg::SEL_LOGIC, 32'hF0F0_1234, 32'h0FF0_FFFF, 1'b1,
			32'hFFF0_FFFF, 1'b0);
		add_alu_row(ex_pkg::ALU_XOR, ex_pkg::SEL_LOGIC, 32'hF0F0_1234, 32'h0FF0_FFFF, 1'b1,
			32'hFF00_EDCB, 1'b0);
		add_alu_row(ex_pkg::ALU_NOR, ex_pkg::SEL_LOGIC, 32'hF0F0_1234, 32'h0FF0_FFFF, 1'b1,
			32'h000F_0000, 1'b0);
		for (int k = 0; k < 2; k++) begin
			a = $random(seed);
			b = $random(seed);
			add_alu_row(ex_pkg::ALU_AND, ex_pkg::SEL_LOGIC, a, b, 1'b1, a & b, 1'b0);
			add_alu_row(ex_pkg::ALU_NOR, ex_pkg::SEL_LOGIC, a, b, 1'b1, ~(a | b), 1'b0);
		end
		// shifts take the amount from reg1, low five bits only
		add_alu_row(ex_pkg::ALU_SLL, ex_pkg::SEL_SHIFT, 32'd4, 32'h0000_00FF, 1'b1,
			32'h0000_0FF0, 1'b0);
		add_alu_row(ex_pkg::ALU_SRL, ex_pkg::SEL_SHIFT, 32'd8, 32'h8000_0000, 1'b1,
			32'h0080_0000, 1'b0);
		add_alu_row(ex_pkg::ALU_SRA, ex_pkg::SEL_SHIFT, 32'd8, 32'h8000_0000, 1'b1,
			32'hFF80_0000, 1'b0);
		add_alu_row(ex_pkg::ALU_SRA, ex_pkg::SEL_SHIFT, 32'h24, 32'hF000_0000, 1'b1,
			32'hFF00_0000, 1'b0);
		add_alu_row(ex_pkg::ALU_SLL, ex_pkg::SEL_SHIFT, 32'hFFFF_FFE1, 32'h4000_0001, 1'b1,
			32'h8000_0002, 1'b0);
		// -1 against 1
		add_alu_row(ex_pkg::ALU_SLT, ex_pkg::SEL_ARITH, 32'hFFFF_FFFF, 32'd1, 1'b1, 32'd1, 1'b0);
		add_alu_row(ex_pkg::ALU_SLTU, ex_pkg::SEL_ARITH, 32'hFFFF_FFFF, 32'd1, 1'b1, 32'd0, 1'b0);
		add_alu_row(ex_pkg::ALU_SLT, ex_pkg::SEL_ARITH, 32'd1, 32'hFFFF_FFFF, 1'b1, 32'd0, 1'b0);
		add_alu_row(ex_pkg::ALU_SLTU, ex_pkg::SEL_ARITH, 32'd1, 32'hFFFF_FFFF, 1'b1, 32'd1, 1'b0);
		add_alu_row(ex_pkg::ALU_CLZ, ex_pkg::SEL_ARITH, 32'h0, 32'h0, 1'b1, 32'd32, 1'b0);
		add_alu_row(ex_pkg::ALU_CLZ, ex_pkg::SEL_ARITH, 32'hFFFF_FFFF, 32'h0, 1'b1, 32'd0, 1'b0);
		add_alu_row(ex_pkg::ALU_CLZ, ex_pkg::SEL_ARITH, 32'h0000_8000, 32'h0, 1'b1, 32'd16, 1'b0);
		add_alu_row(ex_pkg::ALU_CLO, ex_pkg::SEL_ARITH, 32'hFFFF_FFFF, 32'h0, 1'b1, 32'd32, 1'b0);
		add_alu_row(ex_pkg::ALU_CLO, ex_pkg::SEL_ARITH, 32'h0, 32'h0, 1'b1, 32'd0, 1'b0);
		add_alu_row(ex_pkg::ALU_CLO, ex_pkg::SEL_ARITH, 32'hFFFF_7FFF, 32'h0, 1'b1, 32'd16, 1'b0);
		add_alu_row(ex_pkg::ALU_ADD, ex_pkg::SEL_ARITH, 32'h7FFF_FFFF, 32'd1, 1'b1, 32'h0, 1'b1);
		add_alu_row(ex_pkg::ALU_ADDU, ex_pkg::SEL_ARITH, 32'h7FFF_FFFF, 32'd1, 1'b1,
			32'h8000_0000, 1'b0);
		add_alu_row(ex_pkg::ALU_ADD, ex_pkg::SEL_ARITH, 32'd5, 32'hFFFF_FFFD, 1'b1, 32'd2, 1'b0);
		add_alu_row(ex_pkg::ALU_SUB, ex_pkg::SEL_ARITH, 32'h8000_0000, 32'd1, 1'b1, 32'h0, 1'b1);
		add_alu_row(ex_pkg::ALU_SUBU, ex_pkg::SEL_ARITH, 32'h8000_0000, 32'd1, 1'b1,
			32'h7FFF_FFFF, 1'b0);
		add_alu_row(ex_pkg::ALU_ADDI, ex_pkg::SEL_ARITH, 32'h8000_0000, 32'hFFFF_FFFF, 1'b1,
			32'h0, 1'b1);
		add_alu_row(ex_pkg::ALU_ADDIU, ex_pkg::SEL_ARITH, 32'h8000_0000, 32'hFFFF_FFFF, 1'b1,
			32'h7FFF_FFFF, 1'b0);
		add_alu_row(ex_pkg::ALU_SUB, ex_pkg::SEL_ARITH, 32'd10, 32'd3, 1'b1, 32'd7, 1'b0);
		// -3 times 5 is -15
		add_alu_row(ex_pkg::ALU_MUL, ex_pkg::SEL_MUL, 32'hFFFF_FFFD, 32'd5, 1'b1,
			32'hFFFF_FFF1, 1'b0);
		push_hilo_row(ex_pkg::ALU_MULT, ex_pkg::SEL_NONE, 32'hFFFF_FFFD, 32'd5, 1'b0, 1'b0,
			1'b0, 32'h0, 1'b1, 32'hFFFF_FFFF, 32'hFFFF_FFF1);
		push_hilo_row(ex_pkg::ALU_MULTU, ex_pkg::SEL_NONE, 32'hFFFF_FFFD, 32'd5, 1'b0, 1'b0,
			1'b0, 32'h0, 1'b1, 32'h0000_0004, 32'hFFFF_FFF1);
		push_hilo_row(ex_pkg::ALU_MULT, ex_pkg::SEL_NONE, 32'hFFFF_FFFE, 32'hFFFF_FFFE, 1'b0,
			1'b0, 1'b0, 32'h0, 1'b1, 32'h0, 32'd4);
		push_hilo_row(ex_pkg::ALU_MULT, ex_pkg::SEL_NONE, 32'h8000_0000, 32'h8000_0000, 1'b0,
			1'b0, 1'b0, 32'h0, 1'b1, 32'h4000_0000, 32'h0);
		// forwarding priority: mem, then wb, then register file
		push_hilo_row(ex_pkg::ALU_MFHI, ex_pkg::SEL_MOVE, 32'h0, 32'h0, 1'b1, 1'b1, 1'b1,
			MEM_HI, 1'b0, 32'h0, 32'h0);
		push_hilo_row(ex_pkg::ALU_MFHI, ex_pkg::SEL_MOVE, 32'h0, 32'h0, 1'b0, 1'b1, 1'b1,
			WB_HI, 1'b0, 32'h0, 32'h0);
		push_hilo_row(ex_pkg::ALU_MFHI, ex_pkg::SEL_MOVE, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1,
			RF_HI, 1'b0, 32'h0, 32'h0);
		push_hilo_row(ex_pkg::ALU_MFLO, ex_pkg::SEL_MOVE, 32'h0, 32'h0, 1'b1, 1'b0, 1'b1,
			MEM_LO, 1'b0, 32'h0, 32'h0);
		push_hilo_row(ex_pkg::ALU_MFLO, ex_pkg::SEL_MOVE, 32'h0, 32'h0, 1'b0, 1'b1, 1'b1,
			WB_LO, 1'b0, 32'h0, 32'h0);
		push_hilo_row(ex_pkg::ALU_MFLO, ex_pkg::SEL_MOVE, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1,
			RF_LO, 1'b0, 32'h0, 32'h0);
		push_hilo_row(ex_pkg::ALU_MTHI, ex_pkg::SEL_NONE, 32'hABCD_0000, 32'h0, 1'b0, 1'b1,
			1'b0, 32'h0, 1'b1, 32'hABCD_0000, WB_LO);
		push_hilo_row(ex_pkg::ALU_MTLO, ex_pkg::SEL_NONE, 32'h1234_5678, 32'h0, 1'b1, 1'b0,
			1'b0, 32'h0, 1'b1, MEM_HI, 32'h1234_5678);
		push_hilo_row(ex_pkg::ALU_MTHI, ex_pkg::SEL_NONE, 32'h5555_AAAA, 32'h0, 1'b0, 1'b0,
			1'b0, 32'h0, 1'b1, 32'h5555_AAAA, RF_LO);
		add_alu_row(ex_pkg::ALU_MOVZ, ex_pkg::SEL_MOVE, 32'hDEAD_BEEF, 32'h0, 1'b1,
			32'hDEAD_BEEF, 1'b0);
		add_alu_row(ex_pkg::ALU_MOVN, ex_pkg::SEL_MOVE, 32'hCAFE_F00D, 32'h0, 1'b0,
			32'hCAFE_F00D, 1'b0);
		add_alu_row(ex_pkg::ALU_NOP, ex_pkg::SEL_NONE, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0);
	endtask

	////////////////////////////////////////
	// drive and wait
	////////////////////////////////////////

	task automatic apply_inputs(input row_t r);
		aluop <= r.op;
		alusel <= r.sel;
		reg1 <= r.reg1;
		reg2 <= r.reg2;
		wd <= r.wd;
		wreg <= r.wreg;
		mem_whilo <= r.mem_whilo;
		wb_whilo <= r.wb_whilo;
	endtask

	// inputs under reset that would set wreg_o, whilo_o or ov_o
	task automatic drive_reset_load(input int n);
		wreg <= 1'b1;
		if (n % 2 == 0) begin
			aluop <= ex_pkg::ALU_MULT;
			alusel <= ex_pkg::SEL_NONE;
			reg1 <= 32'hFFFF_FFFD;
			reg2 <= 32'd5;
		end else begin
			// overflowing add
			aluop <= ex_pkg::ALU_ADD;
			alusel <= ex_pkg::SEL_ARITH;
			reg1 <= 32'h7FFF_FFFF;
			reg2 <= 32'd1;
		end
	endtask

	task automatic hand_expected(input row_t r);
		exp_wd <= r.wd;
		exp_wreg <= r.exp_wreg;
		exp_wdata <= r.exp_wdata;
		exp_ov <= r.exp_ov;
		exp_hi <= r.exp_hi;
		exp_lo <= r.exp_lo;
		exp_whilo <= r.exp_whilo;
	endtask

	task automatic wait_reset_release(output logic ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < TIMEOUT_CYCLES) begin
			@(posedge clk);
			n++;
			if (!reset_i)
				ok = 1'b1;
			else if (n < RESET_CYCLES - 1)
				drive_reset_load(n);
			else
				apply_inputs(idle_row);
		end
		if (!ok)
			$display("timeout: reset_i still high after %0d cycles", TIMEOUT_CYCLES);
	endtask

	task automatic drain_checks(input int total, output logic ok);
		int n;
		ok = (check_count >= total);
		n = 0;
		while (!ok && n < TIMEOUT_CYCLES) begin
			@(posedge clk);
			n++;
			if (check_count >= total)
				ok = 1'b1;
		end
		if (!ok)
			$display("timeout: only %0d of %0d rows were checked", check_count, total);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset_i = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_i <= 1'b0;
	end

	initial begin
		idle_row = '0;
		aluop = ex_pkg::ALU_NOP;
		alusel = ex_pkg::SEL_NONE;
		reg1 = '0;
		reg2 = '0;
		wd = '0;
		wreg = 1'b0;
		hi = RF_HI;
		lo = RF_LO;
		mem_hi = MEM_HI;
		mem_lo = MEM_LO;
		wb_hi = WB_HI;
		wb_lo = WB_LO;
		mem_whilo = 1'b0;
		wb_whilo = 1'b0;
		check = 1'b0;
		hand_expected(idle_row);
		seed = 89995;
		build_table();
		wait_reset_release(run_ok);
		if (run_ok) begin
			// one row per cycle, its expected values follow a cycle later
			for (int i = 0; i <= rows.size(); i++) begin
				if (i < rows.size())
					apply_inputs(rows[i]);
				else
					apply_inputs(idle_row);
				if (i > 0) begin
					hand_expected(rows[i-1]);
					check <= 1'b1;
				end
				@(posedge clk);
			end
			check <= 1'b0;
			drain_checks(rows.size(), run_ok);
		end
		$display("rows %0d, checked %0d, errors %0d", rows.size(), check_count, error_count);
		if (!run_ok || error_count != 0 || check_count != rows.size())
			$display("TEST RESULT: FAIL");
		else
			$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* include/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// register word and the HI:LO pair
`define EX_DATA_W 32
`define EX_DWORD_W 64

// destination register number
`define EX_REGADDR_W 5

// low operand bits that give a shift amount
`define EX_SHAMT_W 5

////////////////////////////////////////
// decoded control fields
////////////////////////////////////////

// operation code from decode
`define EX_ALUOP_W 8

// result class code from decode
`define EX_ALUSEL_W 3

`endif

/* logic/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_alu (
	input  ex_pkg::aluop_e         aluop_i,
	input  logic [`EX_DATA_W-1:0]  reg1_i,
	input  logic [`EX_DATA_W-1:0]  reg2_i,
	output logic [`EX_DATA_W-1:0]  logic_res_o,
	output logic [`EX_DATA_W-1:0]  shift_res_o,
	output logic [`EX_DATA_W-1:0]  arith_res_o,
	output logic                   overflow_o
);

	// counts leading zeros, 0 to 32
	function automatic logic [`EX_SHAMT_W:0] lead_zeros(input logic [`EX_DATA_W-1:0] word);
		logic [`EX_SHAMT_W:0] count;
		logic                 seen_one;
		count = '0;
		seen_one = 1'b0;
		for (int i = `EX_DATA_W - 1; i >= 0; i--) begin
			if (word[i]) begin
				seen_one = 1'b1;
			end else if (!seen_one) begin
				count = count + 1'b1;
			end
		end
		return count;
	endfunction

	logic [`EX_SHAMT_W-1:0] shamt;
	logic                   sub_sel;
	logic [`EX_DATA_W-1:0]  addend;
	logic [`EX_DATA_W-1:0]  sum;
	logic                   addend_sign;
	logic                   sum_ov;
	logic                   lt_signed;
	logic                   lt_unsigned;
	logic [`EX_SHAMT_W:0]   clz_cnt;
	logic [`EX_SHAMT_W:0]   clo_cnt;

	////////////////////////////////////////
	// shared adder
	////////////////////////////////////////

	assign sub_sel = (aluop_i == ex_pkg::ALU_SUB) || (aluop_i == ex_pkg::ALU_SUBU) ||
		(aluop_i == ex_pkg::ALU_SLT) || (aluop_i == ex_pkg::ALU_SLTU);

	// two's complement of reg2 when subtracting
	assign addend = sub_sel ? (~reg2_i + 1'b1) : reg2_i;
	assign sum = reg1_i + addend;

	// sign of the true second operand, so 0x8000_0000 subtrahend is handled
	assign addend_sign = sub_sel ? ~reg2_i[`EX_DATA_W-1] : reg2_i[`EX_DATA_W-1];
	assign sum_ov = (reg1_i[`EX_DATA_W-1] == addend_sign) &&
		(sum[`EX_DATA_W-1] != reg1_i[`EX_DATA_W-1]);

	// equal signs cannot overflow on subtract, so the sum sign is valid there
	assign lt_signed = (reg1_i[`EX_DATA_W-1] && !reg2_i[`EX_DATA_W-1]) ||
		((reg1_i[`EX_DATA_W-1] == reg2_i[`EX_DATA_W-1]) && sum[`EX_DATA_W-1]);
	assign lt_unsigned = reg1_i < reg2_i;

	// only the trapping forms report overflow
	assign overflow_o = sum_ov && ((aluop_i == ex_pkg::ALU_ADD) ||
		(aluop_i == ex_pkg::ALU_ADDI) || (aluop_i == ex_pkg::ALU_SUB));

	assign clz_cnt = lead_zeros(reg1_i);
	assign clo_cnt = lead_zeros(~reg1_i);

	////////////////////////////////////////
	// logic and shift
	////////////////////////////////////////

	assign shamt = reg1_i[`EX_SHAMT_W-1:0];

	always_comb begin
		case (aluop_i)
			ex_pkg::ALU_AND: logic_res_o = reg1_i & reg2_i;
			ex_pkg::ALU_OR:  logic_res_o = reg1_i | reg2_i;
			ex_pkg::ALU_XOR: logic_res_o = reg1_i ^ reg2_i;
			ex_pkg::ALU_NOR: logic_res_o = ~(reg1_i | reg2_i);
			default:         logic_res_o = '0;
		endcase
	end

	always_comb begin
		case (aluop_i)
			ex_pkg::ALU_SLL: shift_res_o = reg2_i << shamt;
			ex_pkg::ALU_SRL: shift_res_o = reg2_i >> shamt;
			// arithmetic shift keeps the sign of reg2
			ex_pkg::ALU_SRA: shift_res_o = $unsigned($signed(reg2_i) >>> shamt);
			default:         shift_res_o = '0;
		endcase
	end

	////////////////////////////////////////
	// arithmetic result
	////////////////////////////////////////

	always_comb begin
		case (aluop_i)
			ex_pkg::ALU_ADD, ex_pkg::ALU_ADDU, ex_pkg::ALU_ADDI, ex_pkg::ALU_ADDIU,
			ex_pkg::ALU_SUB, ex_pkg::ALU_SUBU: begin
				arith_res_o = sum;
			end
			ex_pkg::ALU_SLT: begin
				arith_res_o = {{(`EX_DATA_W-1){1'b0}}, lt_signed};
			end
			ex_pkg::ALU_SLTU: begin
				arith_res_o = {{(`EX_DATA_W-1){1'b0}}, lt_unsigned};
			end
			ex_pkg::ALU_CLZ: begin
				arith_res_o = {{(`EX_DATA_W-`EX_SHAMT_W-1){1'b0}}, clz_cnt};
			end
			ex_pkg::ALU_CLO: begin
				arith_res_o = {{(`EX_DATA_W-`EX_SHAMT_W-1){1'b0}}, clo_cnt};
			end
			default: begin
				arith_res_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/ex_hilo_move.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_hilo_move (
	input  ex_pkg::aluop_e         aluop_i,
	input  logic [`EX_DATA_W-1:0]  reg1_i,
	input  logic [`EX_DWORD_W-1:0] product_i,
	input  logic [`EX_DATA_W-1:0]  hi_i,
	input  logic [`EX_DATA_W-1:0]  lo_i,
	input  logic [`EX_DATA_W-1:0]  mem_hi_i,
	input  logic [`EX_DATA_W-1:0]  mem_lo_i,
	input  logic [`EX_DATA_W-1:0]  wb_hi_i,
	input  logic [`EX_DATA_W-1:0]  wb_lo_i,
	input  logic                   mem_whilo_i,
	input  logic                   wb_whilo_i,
	output logic [`EX_DATA_W-1:0]  move_res_o,
	output logic [`EX_DATA_W-1:0]  hi_o,
	output logic [`EX_DATA_W-1:0]  lo_o,
	output logic                   whilo_o
);

	logic [`EX_DATA_W-1:0] hi_cur;
	logic [`EX_DATA_W-1:0] lo_cur;

	// newest hi/lo, memory stage is younger than write back
	always_comb begin
		if (mem_whilo_i) begin
			hi_cur = mem_hi_i;
			lo_cur = mem_lo_i;
		end else if (wb_whilo_i) begin
			hi_cur = wb_hi_i;
			lo_cur = wb_lo_i;
		end else begin
			hi_cur = hi_i;
			lo_cur = lo_i;
		end
	end

	// move class results
	always_comb begin
		case (aluop_i)
			ex_pkg::ALU_MFHI:                   move_res_o = hi_cur;
			ex_pkg::ALU_MFLO:                   move_res_o = lo_cur;
			ex_pkg::ALU_MOVZ, ex_pkg::ALU_MOVN: move_res_o = reg1_i;
			default:                            move_res_o = '0;
		endcase
	end

	////////////////////////////////////////
	// hi/lo write request
	////////////////////////////////////////

	always_comb begin
		whilo_o = 1'b1;
		case (aluop_i)
			ex_pkg::ALU_MULT, ex_pkg::ALU_MULTU: begin
				hi_o = product_i[`EX_DWORD_W-1:`EX_DATA_W];
				lo_o = product_i[`EX_DATA_W-1:0];
			end
			// the untouched half keeps its forwarded value
			ex_pkg::ALU_MTHI: begin
				hi_o = reg1_i;
				lo_o = lo_cur;
			end
			ex_pkg::ALU_MTLO: begin
				hi_o = hi_cur;
				lo_o = reg1_i;
			end
			default: begin
				whilo_o = 1'b0;
				hi_o = '0;
				lo_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/ex_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_mul (
	input  ex_pkg::aluop_e         aluop_i,
	input  logic [`EX_DATA_W-1:0]  reg1_i,
	input  logic [`EX_DATA_W-1:0]  reg2_i,
	output logic [`EX_DWORD_W-1:0] product_o
);

	logic                   signed_op;
	logic                   neg_result;
	logic [`EX_DATA_W-1:0]  mag1;
	logic [`EX_DATA_W-1:0]  mag2;
	logic [`EX_DWORD_W-1:0] mag_prod;

	// mul and mult treat operands as signed, multu does not
	assign signed_op = (aluop_i == ex_pkg::ALU_MUL) || (aluop_i == ex_pkg::ALU_MULT);

	// magnitudes of negative operands
	assign mag1 = (signed_op && reg1_i[`EX_DATA_W-1]) ? (~reg1_i + 1'b1) : reg1_i;
	assign mag2 = (signed_op && reg2_i[`EX_DATA_W-1]) ? (~reg2_i + 1'b1) : reg2_i;

	assign mag_prod = {{`EX_DATA_W{1'b0}}, mag1} * {{`EX_DATA_W{1'b0}}, mag2};

	// product is negative only when the signs differ
	assign neg_result = signed_op && (reg1_i[`EX_DATA_W-1] ^ reg2_i[`EX_DATA_W-1]);

	assign product_o = neg_result ? (~mag_prod + 1'b1) : mag_prod;

endmodule

`default_nettype wire

/* logic/ex_pkg.sv */
`default_nettype none

`include "ex_macros.svh"

package ex_pkg;

	// operation codes, kept in the decode stage encoding
	typedef enum logic [`EX_ALUOP_W-1:0] {
		ALU_NOP   = 8'b0000_0000,
		ALU_AND   = 8'b0010_0100,
		ALU_OR    = 8'b0010_0101,
		ALU_XOR   = 8'b0010_0110,
		ALU_NOR   = 8'b0010_0111,
		ALU_SLL   = 8'b0111_1100,
		ALU_SRL   = 8'b0000_0010,
		ALU_SRA   = 8'b0000_0011,
		ALU_MOVZ  = 8'b0000_1010,
		ALU_MOVN  = 8'b0000_1011,
		ALU_MFHI  = 8'b0001_0000,
		ALU_MTHI  = 8'b0001_0001,
		ALU_MFLO  = 8'b0001_0010,
		ALU_MTLO  = 8'b0001_0011,
		ALU_SLT   = 8'b0010_1010,
		ALU_SLTU  = 8'b0010_1011,
		ALU_ADD   = 8'b0010_0000,
		ALU_ADDU  = 8'b0010_0001,
		ALU_SUB   = 8'b0010_0010,
		ALU_SUBU  = 8'b0010_0011,
		ALU_ADDI  = 8'b0101_0101,
		ALU_ADDIU = 8'b0101_0110,
		ALU_CLZ   = 8'b1011_0000,
		ALU_CLO   = 8'b1011_0001,
		ALU_MULT  = 8'b0001_1000,
		ALU_MULTU = 8'b0001_1001,
		ALU_MUL   = 8'b1010_1001
	} aluop_e;

	// result class picked for write back
	typedef enum logic [`EX_ALUSEL_W-1:0] {
		SEL_NONE  = 3'b000,
		SEL_LOGIC = 3'b001,
		SEL_SHIFT = 3'b010,
		SEL_MOVE  = 3'b011,
		SEL_ARITH = 3'b100,
		SEL_MUL   = 3'b101
	} alusel_e;

endpackage

`default_nettype wire

/* logic/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_stage (
	input  logic                      clk,
	input  logic                      reset_i,
	input  ex_pkg::aluop_e            aluop_i,
	input  ex_pkg::alusel_e           alusel_i,
	input  logic [`EX_DATA_W-1:0]     reg1_i,
	input  logic [`EX_DATA_W-1:0]     reg2_i,
	input  logic [`EX_REGADDR_W-1:0]  wd_i,
	input  logic                      wreg_i,
	input  logic [`EX_DATA_W-1:0]     hi_i,
	input  logic [`EX_DATA_W-1:0]     lo_i,
	input  logic [`EX_DATA_W-1:0]     mem_hi_i,
	input  logic [`EX_DATA_W-1:0]     mem_lo_i,
	input  logic [`EX_DATA_W-1:0]     wb_hi_i,
	input  logic [`EX_DATA_W-1:0]     wb_lo_i,
	input  logic                      mem_whilo_i,
	input  logic                      wb_whilo_i,
	output logic [`EX_REGADDR_W-1:0]  wd_o,
	output logic                      wreg_o,
	output logic [`EX_DATA_W-1:0]     wdata_o,
	output logic                      ov_o,
	output logic [`EX_DATA_W-1:0]     hi_o,
	output logic [`EX_DATA_W-1:0]     lo_o,
	output logic                      whilo_o
);

	logic [`EX_DATA_W-1:0]  logic_res;
	logic [`EX_DATA_W-1:0]  shift_res;
	logic [`EX_DATA_W-1:0]  arith_res;
	logic [`EX_DATA_W-1:0]  move_res;
	logic [`EX_DWORD_W-1:0] product;
	logic                   overflow;
	logic [`EX_DATA_W-1:0]  hi_next;
	logic [`EX_DATA_W-1:0]  lo_next;
	logic                   whilo_next;
	logic [`EX_DATA_W-1:0]  wdata_next;

	ex_alu u_alu (
		.aluop_i     (aluop_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.logic_res_o (logic_res),
		.shift_res_o (shift_res),
		.arith_res_o (arith_res),
		.overflow_o  (overflow)
	);

	ex_mul u_mul (
		.aluop_i   (aluop_i),
		.reg1_i    (reg1_i),
		.reg2_i    (reg2_i),
		.product_o (product)
	);

	ex_hilo_move u_hilo_move (
		.aluop_i     (aluop_i),
		.reg1_i      (reg1_i),
		.product_i   (product),
		.hi_i        (hi_i),
		.lo_i        (lo_i),
		.mem_hi_i    (mem_hi_i),
		.mem_lo_i    (mem_lo_i),
		.wb_hi_i     (wb_hi_i),
		.wb_lo_i     (wb_lo_i),
		.mem_whilo_i (mem_whilo_i),
		.wb_whilo_i  (wb_whilo_i),
		.move_res_o  (move_res),
		.hi_o        (hi_next),
		.lo_o        (lo_next),
		.whilo_o     (whilo_next)
	);

	// write data by result class, mul keeps the low product word
	always_comb begin
		case (alusel_i)
			ex_pkg::SEL_LOGIC: wdata_next = logic_res;
			ex_pkg::SEL_SHIFT: wdata_next = shift_res;
			ex_pkg::SEL_MOVE:  wdata_next = move_res;
			ex_pkg::SEL_ARITH: wdata_next = arith_res;
			ex_pkg::SEL_MUL:   wdata_next = product[`EX_DATA_W-1:0];
			default:           wdata_next = '0;
		endcase
	end

	////////////////////////////////////////
	// output register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wd_o <= '0;
			wreg_o <= 1'b0;
			wdata_o <= '0;
			ov_o <= 1'b0;
			hi_o <= '0;
			lo_o <= '0;
			whilo_o <= 1'b0;
		end else begin
			wd_o <= wd_i;
			// overflow drops the register write
			wreg_o <= wreg_i & ~overflow;
			wdata_o <= wdata_next;
			ov_o <= overflow;
			hi_o <= hi_next;
			lo_o <= lo_next;
			whilo_o <= whilo_next;
		end
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_mul.sv
logic/ex_hilo_move.sv
logic/ex_stage.sv
bench/ex_checker.sv
bench/tb_ex_stage.sv
